// ==== Bender.yml ====
package:
  name: pkt_ingress

sources:
  - pkt_pkg.sv
  - in_wr_controller_fsm.sv
  - pkt_fifo.sv
  - crc16_acc.sv
  - out_arbiter.sv
  - pkt_ingress_top.sv
  - target: test
    files:
      - tb_pkt_ingress.sv

// ==== crc16_acc.sv ====
`timescale 1ns/1ps

module crc16_acc (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              clr_n,
    input  logic                              en,
    input  logic [pkt_pkg::data_width-1:0]    data,
    output logic [pkt_pkg::data_width-1:0]    crc
);

    // Folds one whole word into the register, one bit per iteration.
    function automatic logic [pkt_pkg::data_width-1:0] crc_step(
        input logic [pkt_pkg::data_width-1:0] c_in,
        input logic [pkt_pkg::data_width-1:0] d
    );
        logic [pkt_pkg::data_width-1:0] c;
        logic                           fb;
        c = c_in;
        for (int i = pkt_pkg::data_width - 1; i >= 0; i--) begin
            fb = c[pkt_pkg::data_width-1] ^ d[i];
            c  = {c[pkt_pkg::data_width-2:0], 1'b0};
            if (fb) begin
                c = c ^ pkt_pkg::crc_poly;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= pkt_pkg::crc_init;
        end else if (!clr_n) begin
            crc <= pkt_pkg::crc_init;
        end else if (en) begin
            crc <= crc_step(crc, data);
        end
    end

endmodule

// ==== in_wr_controller_fsm.sv ====
`timescale 1ns/1ps

module in_wr_controller_fsm (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              sop,
    input  logic                              valid,
    input  logic                              eop,
    input  logic                              ready,
    input  logic [pkt_pkg::data_width-1:0]    ctrl_data_in,
    output logic                              wr_en,
    output logic                              fifo_rst_n,
    output logic                              crc_rst_n,
    output logic                              done,
    output logic [pkt_pkg::data_width-1:0]    ctrl_data_reg
);

    pkt_pkg::ctrl_state_e              state;
    pkt_pkg::ctrl_state_e              state_nxt;
    logic [pkt_pkg::len_width-1:0]     cnt;
    logic                              cnt_eq_len;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pkt_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (state == pkt_pkg::ST_IDLE) begin
            cnt <= '0;
        end else if (state == pkt_pkg::ST_WR && valid) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == pkt_pkg::ST_LOAD) begin
            ctrl_data_reg <= ctrl_data_in;   // Header word arrives the cycle after sop.
        end
    end

    assign cnt_eq_len = (cnt == ctrl_data_reg[pkt_pkg::len_width-1:0]);

    always_comb begin
        state_nxt = state;
        case (state)
            pkt_pkg::ST_IDLE: begin
                if (sop) begin
                    state_nxt = pkt_pkg::ST_LOAD;
                end
            end
            pkt_pkg::ST_LOAD: state_nxt = pkt_pkg::ST_WR;
            pkt_pkg::ST_WR: begin
                if (eop) begin
                    state_nxt = cnt_eq_len ? pkt_pkg::ST_WAIT : pkt_pkg::ST_ERROR;
                end
            end
            pkt_pkg::ST_WAIT: begin
                if (ready) begin
                    state_nxt = pkt_pkg::ST_IDLE;
                end
            end
            default: state_nxt = pkt_pkg::ST_IDLE;
        endcase
    end

    assign wr_en      = (state == pkt_pkg::ST_WR) && !eop;
    assign done       = (state == pkt_pkg::ST_WAIT);
    assign fifo_rst_n = (state != pkt_pkg::ST_ERROR);
    // CRC goes back to its seed once the packet has left or was dropped.
    assign crc_rst_n  = !((state == pkt_pkg::ST_ERROR) ||
                          (state == pkt_pkg::ST_WAIT && ready));

    a_eop_not_valid: assert property (
        @(posedge clk) disable iff (!rst_n) !(eop && valid)
    );

endmodule

// ==== out_arbiter.sv ====
`timescale 1ns/1ps

module out_arbiter (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [pkt_pkg::num_ports-1:0]     done,
    input  logic [pkt_pkg::data_width-1:0]    hdr_0,
    input  logic [pkt_pkg::data_width-1:0]    hdr_1,
    input  logic [pkt_pkg::data_width-1:0]    fifo_data_0,
    input  logic [pkt_pkg::data_width-1:0]    fifo_data_1,
    input  logic [pkt_pkg::data_width-1:0]    crc_0,
    input  logic [pkt_pkg::data_width-1:0]    crc_1,
    output logic [pkt_pkg::num_ports-1:0]     rd_en,
    output logic [pkt_pkg::num_ports-1:0]     ready,
    output logic                              out_valid,
    output logic                              out_sop,
    output logic                              out_eop,
    output logic                              out_port,
    output logic [pkt_pkg::data_width-1:0]    out_data
);

    pkt_pkg::arb_state_e               state;
    logic [pkt_pkg::num_ports-1:0]     gnt;
    logic [pkt_pkg::num_ports-1:0]     avail;
    logic                              prio;
    logic                              pick;
    logic                              sel;
    logic [pkt_pkg::len_width-1:0]     len;
    logic [pkt_pkg::len_width-1:0]     cnt;
    logic [pkt_pkg::len_width-1:0]     cnt_nxt;

    // A port being released this cycle still shows done, so it is masked.
    assign avail   = done & ~ready;
    assign pick    = avail[prio] ? prio : ~prio;
    assign sel     = gnt[1];
    assign len     = sel ? hdr_1[pkt_pkg::len_width-1:0] : hdr_0[pkt_pkg::len_width-1:0];
    assign cnt_nxt = cnt + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pkt_pkg::ARB_IDLE;
            gnt   <= '0;
            prio  <= 1'b0;
            cnt   <= '0;
            ready <= '0;
        end else begin
            ready <= '0;
            case (state)
                pkt_pkg::ARB_IDLE: begin
                    if (|avail) begin
                        gnt       <= '0;
                        gnt[pick] <= 1'b1;
                        prio      <= ~pick;     // Next turn favours the other port.
                        state     <= pkt_pkg::ARB_HDR;
                    end
                end
                pkt_pkg::ARB_HDR: begin
                    cnt <= '0;
                    if (len == '0) begin
                        state <= pkt_pkg::ARB_CRC;
                    end else begin
                        state <= pkt_pkg::ARB_DATA;
                    end
                end
                pkt_pkg::ARB_DATA: begin
                    cnt <= cnt_nxt;
                    if (cnt_nxt == len) begin
                        state <= pkt_pkg::ARB_CRC;
                    end
                end
                default: begin
                    ready <= gnt;
                    gnt   <= '0;
                    state <= pkt_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        out_valid = (state != pkt_pkg::ARB_IDLE);
        out_sop   = (state == pkt_pkg::ARB_HDR);
        out_eop   = (state == pkt_pkg::ARB_CRC);
        out_port  = sel;
        out_data  = '0;
        rd_en     = '0;
        case (state)
            pkt_pkg::ARB_HDR:  out_data = sel ? hdr_1 : hdr_0;
            pkt_pkg::ARB_DATA: begin
                out_data = sel ? fifo_data_1 : fifo_data_0;
                rd_en    = gnt;
            end
            pkt_pkg::ARB_CRC:  out_data = sel ? crc_1 : crc_0;
            default:           out_data = '0;
        endcase
    end

    a_gnt_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) (state != pkt_pkg::ARB_IDLE) |-> $onehot(gnt)
    );
    a_rd_only_done: assert property (
        @(posedge clk) disable iff (!rst_n) (rd_en & ~done) == '0
    );

endmodule

// ==== pkt_fifo.sv ====
`timescale 1ns/1ps

module pkt_fifo (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              clr_n,
    input  logic                              wr_en,
    input  logic                              rd_en,
    input  logic [pkt_pkg::data_width-1:0]    wr_data,
    output logic [pkt_pkg::data_width-1:0]    rd_data,
    output logic                              empty,
    output logic                              full
);

    logic [pkt_pkg::data_width-1:0] mem [pkt_pkg::fifo_depth];
    logic [pkt_pkg::fifo_aw-1:0]    wr_ptr;
    logic [pkt_pkg::fifo_aw-1:0]    rd_ptr;
    logic [pkt_pkg::fifo_aw:0]      count;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (!clr_n) begin
            wr_ptr <= '0;                   // Flush drops whatever was stored.
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rd_data = mem[rd_ptr];   // Head word is always visible.
    assign empty   = (count == '0);
    assign full    = (count == pkt_pkg::fifo_depth);

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && full));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && empty));

endmodule

// ==== pkt_ingress_top.sv ====
`timescale 1ns/1ps

module pkt_ingress_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [pkt_pkg::num_ports-1:0]     sop,
    input  logic [pkt_pkg::num_ports-1:0]     valid,
    input  logic [pkt_pkg::num_ports-1:0]     eop,
    input  logic [pkt_pkg::data_width-1:0]    data_0,
    input  logic [pkt_pkg::data_width-1:0]    data_1,
    output logic                              out_valid,
    output logic                              out_sop,
    output logic                              out_eop,
    output logic                              out_port,
    output logic [pkt_pkg::data_width-1:0]    out_data
);

    logic [pkt_pkg::data_width-1:0] data_in [pkt_pkg::num_ports];
    logic [pkt_pkg::data_width-1:0] hdr     [pkt_pkg::num_ports];
    logic [pkt_pkg::data_width-1:0] fifo_q  [pkt_pkg::num_ports];
    logic [pkt_pkg::data_width-1:0] crc_q   [pkt_pkg::num_ports];
    logic [pkt_pkg::num_ports-1:0]  wr_en;
    logic [pkt_pkg::num_ports-1:0]  fifo_clr_n;
    logic [pkt_pkg::num_ports-1:0]  crc_clr_n;
    logic [pkt_pkg::num_ports-1:0]  done;
    logic [pkt_pkg::num_ports-1:0]  rd_en;
    logic [pkt_pkg::num_ports-1:0]  ready;

    assign data_in[0] = data_0;
    assign data_in[1] = data_1;

    for (genvar p = 0; p < pkt_pkg::num_ports; p++) begin : g_port
        in_wr_controller_fsm u_ctrl (
            .clk           (clk),
            .rst_n         (rst_n),
            .sop           (sop[p]),
            .valid         (valid[p]),
            .eop           (eop[p]),
            .ready         (ready[p]),
            .ctrl_data_in  (data_in[p]),
            .wr_en         (wr_en[p]),
            .fifo_rst_n    (fifo_clr_n[p]),
            .crc_rst_n     (crc_clr_n[p]),
            .done          (done[p]),
            .ctrl_data_reg (hdr[p])
        );

        pkt_fifo u_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .clr_n   (fifo_clr_n[p]),
            .wr_en   (wr_en[p] & valid[p]),
            .rd_en   (rd_en[p]),
            .wr_data (data_in[p]),
            .rd_data (fifo_q[p]),
            .empty   (),
            .full    ()
        );

        crc16_acc u_crc (
            .clk   (clk),
            .rst_n (rst_n),
            .clr_n (crc_clr_n[p]),
            .en    (wr_en[p] & valid[p]),
            .data  (data_in[p]),
            .crc   (crc_q[p])
        );
    end

    out_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .done        (done),
        .hdr_0       (hdr[0]),
        .hdr_1       (hdr[1]),
        .fifo_data_0 (fifo_q[0]),
        .fifo_data_1 (fifo_q[1]),
        .crc_0       (crc_q[0]),
        .crc_1       (crc_q[1]),
        .rd_en       (rd_en),
        .ready       (ready),
        .out_valid   (out_valid),
        .out_sop     (out_sop),
        .out_eop     (out_eop),
        .out_port    (out_port),
        .out_data    (out_data)
    );

endmodule

// ==== pkt_pkg.sv ====
package pkt_pkg;

    localparam int data_width = 16;
    localparam int len_width  = 5;       // Low header bits carry the payload length.
    localparam int fifo_depth = 32;
    localparam int fifo_aw    = 5;
    localparam int num_ports  = 2;

    localparam logic [data_width-1:0] crc_init = 16'hFFFF;
    localparam logic [data_width-1:0] crc_poly = 16'h1021; // CCITT, MSB first, no final xor.

    typedef enum logic [2:0] {
        ST_IDLE  = 3'b110,
        ST_LOAD  = 3'b001,
        ST_WR    = 3'b011,
        ST_WAIT  = 3'b010,
        ST_ERROR = 3'b111
    } ctrl_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'b00,
        ARB_HDR  = 2'b01,
        ARB_DATA = 2'b10,
        ARB_CRC  = 2'b11
    } arb_state_e;

endpackage

// ==== pkt_stimulus.txt ====
0 04 04 FFFF 1772
1 04 04 FFFF 1772
0 03 05 FFFF 0000
1 02 02 FFFF 0000
0 03 03 FFFF 1021
1 01 01 FFF0 F1EF
0 00 00 0000 FFFF
1 02 01 1234 0000
0 01 01 7FFF 1B98
1 01 01 FFFD 2042
0 05 05 FFFF F452
1 00 00 0000 FFFF
1 03 03 FFFF 1021

// ==== tb_pkt_ingress.sv ====
`timescale 1ns/1ps

module tb_pkt_ingress;

    logic                           clk;
    logic                           rst_n;
    logic                           sop_r   [pkt_pkg::num_ports];
    logic                           valid_r [pkt_pkg::num_ports];
    logic                           eop_r   [pkt_pkg::num_ports];
    logic [pkt_pkg::data_width-1:0] data_r  [pkt_pkg::num_ports];
    logic                           out_valid;
    logic                           out_sop;
    logic                           out_eop;
    logic                           out_port;
    logic [pkt_pkg::data_width-1:0] out_data;

    int                             pk_port  [$];
    int                             pk_decl  [$];
    int                             pk_act   [$];
    int                             pk_first [$];
    int                             pk_crc   [$];
    logic [pkt_pkg::data_width-1:0] exp_q0   [$];
    logic [pkt_pkg::data_width-1:0] exp_q1   [$];
    int                             pend     [pkt_pkg::num_ports];
    bit                             drv_done [pkt_pkg::num_ports];
    int                             errors;
    int                             checked;
    int                             expected_pkts;
    bit                             in_pkt;
    bit                             alt_check;
    int                             alt_port;
    int                             cur_port;
    int                             idx;
    int                             total;

    pkt_ingress_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .sop       ({sop_r[1], sop_r[0]}),
        .valid     ({valid_r[1], valid_r[0]}),
        .eop       ({eop_r[1], eop_r[0]}),
        .data_0    (data_r[0]),
        .data_1    (data_r[1]),
        .out_valid (out_valid),
        .out_sop   (out_sop),
        .out_eop   (out_eop),
        .out_port  (out_port),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    function void push_expected(input int p, input logic [pkt_pkg::data_width-1:0] w);
        if (p == 0) begin
            exp_q0.push_back(w);
        end else begin
            exp_q1.push_back(w);
        end
    endfunction

    function logic [pkt_pkg::data_width-1:0] pop_expected(input int p);
        if (p == 0) begin
            return exp_q0.pop_front();
        end
        return exp_q1.pop_front();
    endfunction

    function int expected_count(input int p);
        return (p == 0) ? exp_q0.size() : exp_q1.size();
    endfunction

    for (genvar g = 0; g < pkt_pkg::num_ports; g++) begin : g_drv
        task send_packet(input int k);
            logic [pkt_pkg::data_width-1:0] hdr;
            int                             n_gap;
            hdr = (k << 8) | pk_decl[k];           // Line index above the length field.
            sop_r[g]  <= 1'b1;
            data_r[g] <= '0;
            @(posedge clk);
            sop_r[g]  <= 1'b0;
            data_r[g] <= hdr;
            for (int i = 0; i < pk_act[k]; i++) begin
                n_gap = $urandom % 3;
                repeat (n_gap) begin
                    @(posedge clk);
                    valid_r[g] <= 1'b0;
                end
                @(posedge clk);
                valid_r[g] <= 1'b1;
                data_r[g]  <= pk_first[k] + i;
            end
            @(posedge clk);
            valid_r[g] <= 1'b0;
            eop_r[g]   <= 1'b1;
            if (pk_decl[k] == pk_act[k]) begin
                push_expected(g, hdr);
                for (int i = 0; i < pk_act[k]; i++) begin
                    push_expected(g, pk_first[k] + i);
                end
                push_expected(g, pk_crc[k]);
                pend[g]++;
            end
            @(posedge clk);
            eop_r[g] <= 1'b0;
        endtask

        initial begin
            int cycles;
            int gap;
            bit first;
            bit abort;
            cycles = 0;
            first  = 1'b1;
            abort  = 1'b0;
            while (rst_n !== 1'b1 && cycles < 100) begin
                @(posedge clk);
                cycles++;
            end
            if (rst_n !== 1'b1) begin
                errors++;
                abort = 1'b1;
                $display("Timeout: reset was never released before port %0d could send", g);
            end
            for (int k = 0; k < pk_port.size(); k++) begin
                if (pk_port[k] == g && !abort) begin
                    cycles = 0;
                    while (pend[g] != 0 && cycles < 2000) begin   // Previous packet must leave.
                        @(negedge clk);
                        cycles++;
                    end
                    if (pend[g] != 0) begin
                        errors++;
                        abort = 1'b1;
                        $display("Timeout: port %0d packet never left the output bus", g);
                    end else begin
                        gap = first ? 2 : 2 + $urandom % 3;
                        repeat (gap) @(posedge clk);
                        first = 1'b0;
                        send_packet(k);
                    end
                end
            end
            drv_done[g] = 1'b1;
        end
    end

    // Outputs are sampled on the falling edge, half a cycle after they settle.
    always @(negedge clk) begin : monitor
        logic [pkt_pkg::data_width-1:0] exp_word;
        if (!in_pkt && out_sop === 1'b1) begin
            if (expected_count(out_port) == 0) begin
                errors++;
                $display("Packet on port %0d at %0t matches no sent good packet", out_port, $time);
            end else begin
                if (alt_check) begin
                    check_value("out_port", out_port, alt_port);
                end
                alt_check = 1'b0;
                in_pkt    = 1'b1;
                idx       = 0;
                cur_port  = out_port;
            end
        end else if (!in_pkt) begin
            check_value("out_valid", out_valid, 1'b0);
        end
        if (in_pkt) begin
            exp_word = pop_expected(cur_port);
            if (idx == 0) begin
                total = exp_word[pkt_pkg::len_width-1:0] + 2;
            end
            check_value("out_valid", out_valid, 1'b1);
            check_value("out_port", out_port, cur_port);
            check_value("out_sop", out_sop, idx == 0);
            check_value("out_eop", out_eop, idx == total - 1);
            check_value("out_data", out_data, exp_word);
            idx++;
            if (idx == total) begin
                in_pkt    = 1'b0;
                pend[cur_port]--;
                checked++;
                alt_check = (pend[1 - cur_port] != 0);   // Other port already done.
                alt_port  = 1 - cur_port;
            end
        end
    end

    initial begin
        int fd;
        int f_port;
        int f_decl;
        int f_act;
        int f_first;
        int f_crc;
        int cycles;
        rst_n = 1'b0;
        for (int p = 0; p < pkt_pkg::num_ports; p++) begin
            sop_r[p]   = 1'b0;
            valid_r[p] = 1'b0;
            eop_r[p]   = 1'b0;
            data_r[p]  = '0;
        end
        void'($urandom(80));
        fd = $fopen("pkt_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file pkt_stimulus.txt");
        end else begin
            while ($fscanf(fd, "%h %h %h %h %h\n", f_port, f_decl, f_act, f_first,
                           f_crc) == 5) begin
                pk_port.push_back(f_port);
                pk_decl.push_back(f_decl);
                pk_act.push_back(f_act);
                pk_first.push_back(f_first);
                pk_crc.push_back(f_crc);
                if (f_decl == f_act) begin
                    expected_pkts++;
                end
            end
            $fclose(fd);
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (!(drv_done[0] && drv_done[1] && pend[0] == 0 && pend[1] == 0 && !in_pkt)
               && cycles < 50000) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= 50000) begin
            errors++;
            $display("Timeout: traffic did not drain from the output bus");
        end
        repeat (20) @(posedge clk);   // Dropped packets must stay silent.
        if (checked != expected_pkts) begin
            errors++;
            $display("Only %0d of %0d good packets came out", checked, expected_pkts);
        end
        $display("Summary: %0d errors, %0d of %0d packets checked", errors, checked,
                 expected_pkts);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
pkt_pkg.sv
in_wr_controller_fsm.sv
pkt_fifo.sv
crc16_acc.sv
out_arbiter.sv
pkt_ingress_top.sv
tb_pkt_ingress.sv
